/* Bender.yml */
package:
  name: execute

sources:
  - hdl/execPkg.sv
  - hdl/alu.sv
  - hdl/lsu.sv
  - hdl/execute.sv
  - target: test
    files:
      - tests/execute_tb.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [execPkg::XLEN-1:0] i_op1,
    input  logic [execPkg::XLEN-1:0] i_op2,
    input  execPkg::aluOp_e          i_opcode,
    output logic [execPkg::XLEN-1:0] o_res
);

    // ------------------------------
    // Shared terms
    // ------------------------------
    logic [4:0]               shamt;             // Only the low five bits shift
    logic                     ltSigned;
    logic                     ltUnsigned;
    logic [execPkg::XLEN-1:0] sraRes;

    assign shamt      = i_op2[4:0];
    assign ltSigned   = $signed(i_op1) < $signed(i_op2);
    assign ltUnsigned = i_op1 < i_op2;
    assign sraRes     = $unsigned($signed(i_op1) >>> shamt); // Sign bit fills from the left

    // ------------------------------
    // Operation select
    // ------------------------------
    always_comb begin
        case (i_opcode)
            execPkg::ADD: begin
                o_res = i_op1 + i_op2;
            end
            execPkg::SUB: begin
                o_res = i_op1 - i_op2;
            end
            execPkg::SLL: begin
                o_res = i_op1 << shamt;
            end
            execPkg::SLT: begin
                o_res = {{(execPkg::XLEN-1){1'b0}}, ltSigned};   // Result is 0 or 1
            end
            execPkg::SLTU: begin
                o_res = {{(execPkg::XLEN-1){1'b0}}, ltUnsigned};
            end
            execPkg::XOR: begin
                o_res = i_op1 ^ i_op2;
            end
            execPkg::SRL: begin
                o_res = i_op1 >> shamt;                          // Zero fill
            end
            execPkg::SRA: begin
                o_res = sraRes;
            end
            execPkg::OR: begin
                o_res = i_op1 | i_op2;
            end
            execPkg::AND: begin
                o_res = i_op1 & i_op2;
            end
            default: begin
                o_res = '0;                                      // Unused encodings give zero
            end
        endcase
    end

endmodule

/* hdl/execPkg.sv */
package execPkg;

    // ------------------------------
    // Datapath width
    // ------------------------------
    localparam int XLEN = 32;                      // Data and address width

    // ------------------------------
    // ALU operations
    // ------------------------------
    // Encoded as {funct7[5], funct3} so decode can cast the instruction bits directly
    typedef enum logic [3:0] {
        ADD  = 4'b0000,                            // Also used for addresses and LUI/AUIPC/JAL
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,                            // Signed compare
        SLTU = 4'b0011,                            // Unsigned compare
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,                            // Arithmetic right shift
        OR   = 4'b0110,
        AND  = 4'b0111
    } aluOp_e;

    // ALU control field coming from decode
    localparam logic [1:0] ALU_CTRL_ADD   = 2'b00; // Force an addition
    localparam logic [1:0] ALU_CTRL_FUNCT = 2'b01; // Decode from funct3 and funct7

    // ------------------------------
    // Memory access
    // ------------------------------
    // Taken from funct3[1:0] and driven unchanged onto the bus width field
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memWidth_e;

    // Load/store unit handshake states
    typedef enum logic {
        IDLE     = 1'b0,                           // No access outstanding
        WAIT_GNT = 1'b1                            // Request held until the bus grants
    } lsuState_e;

endpackage

/* hdl/execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic                     i_CLK,
    input  logic                     i_rst,
    input  logic                     i_en,

    // Decoded instruction
    input  logic [execPkg::XLEN-1:0] i_pc,
    input  logic [2:0]               i_funct3,
    input  logic [6:0]               i_funct7,
    input  logic [4:0]               i_rdPtr,
    input  logic [execPkg::XLEN-1:0] i_rs1,
    input  logic [execPkg::XLEN-1:0] i_rs2,
    input  logic [execPkg::XLEN-1:0] i_immVal,
    input  logic [1:0]               i_aluOp,
    input  logic                     i_regWe,
    input  logic                     i_memWe,
    input  logic                     i_memRe,
    input  logic                     i_imm,
    input  logic                     i_jal,
    input  logic                     i_lui,
    input  logic                     i_auipc,

    // Writeback
    output logic [execPkg::XLEN-1:0] o_rd,
    output logic [4:0]               o_rdPtr,
    output logic                     o_regWe,
    output logic                     o_busy,

    // Bus
    input  logic [execPkg::XLEN-1:0] i_lsuRdata,
    output logic [execPkg::XLEN-1:0] o_lsuWdata,
    output logic [execPkg::XLEN-1:0] o_lsuAddr,
    output logic                     o_lsuWe,
    output execPkg::memWidth_e       o_lsuHb,
    output logic                     o_lsuReq,
    input  logic                     i_lsuGnt
);

    // ------------------------------
    // ALU
    // ------------------------------
    logic [execPkg::XLEN-1:0] aluOp1;
    logic [execPkg::XLEN-1:0] aluOp2;
    logic [execPkg::XLEN-1:0] aluRes;
    execPkg::aluOp_e          aluOpcode;

    always_comb begin
        if (i_aluOp == execPkg::ALU_CTRL_FUNCT) begin
            aluOpcode = execPkg::aluOp_e'({i_funct7[5] & ~i_imm, i_funct3}); // Immediates ignore funct7
        end else begin
            aluOpcode = execPkg::ADD;
        end
    end

    always_comb begin
        if (i_auipc || i_jal) begin
            aluOp1 = i_pc;
        end else if (i_lui) begin
            aluOp1 = '0;                           // LUI passes the immediate through
        end else begin
            aluOp1 = i_rs1;
        end
    end

    assign aluOp2 = i_imm ? i_immVal : i_rs2;

    alu u_alu (
        .i_op1    (aluOp1),
        .i_op2    (aluOp2),
        .i_opcode (aluOpcode),
        .o_res    (aluRes)
    );

    // ------------------------------
    // Load/store unit
    // ------------------------------
    logic                     memOp;
    logic                     lsuStart;
    logic                     lsuDone;
    logic [execPkg::XLEN-1:0] lsuRdata;
    logic [4:0]               pendPtr;
    logic                     pendWe;

    assign memOp    = i_memRe || i_memWe;
    assign lsuStart = i_en && memOp;

    lsu u_lsu (
        .i_CLK      (i_CLK),
        .i_rst      (i_rst),
        .i_start    (lsuStart),
        .i_we       (i_memWe),
        .i_addr     (aluRes),                  // Address is rs1 plus the immediate
        .i_wdata    (i_rs2),
        .i_width    (execPkg::memWidth_e'(i_funct3[1:0])),
        .i_uload    (i_funct3[2]),
        .o_rdata    (lsuRdata),
        .o_done     (lsuDone),
        .o_busy     (o_busy),
        .i_lsuRdata (i_lsuRdata),
        .o_lsuWdata (o_lsuWdata),
        .o_lsuAddr  (o_lsuAddr),
        .o_lsuWe    (o_lsuWe),
        .o_lsuHb    (o_lsuHb),
        .o_lsuReq   (o_lsuReq),
        .i_lsuGnt   (i_lsuGnt)
    );

    // Destination of the access in flight
    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            pendWe  <= 1'b0;
            pendPtr <= '0;
        end else if (lsuStart) begin
            pendWe  <= i_regWe && i_memRe;         // Stores never write back
            pendPtr <= i_rdPtr;
        end
    end

    // ------------------------------
    // Writeback register
    // ------------------------------
    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            o_rd    <= '0;
            o_rdPtr <= '0;
            o_regWe <= 1'b0;
        end else if (lsuDone) begin
            o_rd    <= lsuRdata;                   // Load data lands the cycle after grant
            o_rdPtr <= pendPtr;
            o_regWe <= pendWe;
        end else if (i_en && !memOp) begin
            o_rd    <= aluRes;
            o_rdPtr <= i_rdPtr;
            o_regWe <= i_regWe;
        end else begin
            o_regWe <= 1'b0;                       // Pulse lasts a single cycle
        end
    end

    // Decode has to hold off while a bus access is outstanding
    assert property (@(posedge i_CLK) disable iff (i_rst) i_en |-> !o_busy);

endmodule

/* hdl/lsu.sv */
`timescale 1ns/1ps

module lsu (
    input  logic                     i_CLK,
    input  logic                     i_rst,

    // Core side
    input  logic                     i_start,
    input  logic                     i_we,
    input  logic [execPkg::XLEN-1:0] i_addr,
    input  logic [execPkg::XLEN-1:0] i_wdata,
    input  execPkg::memWidth_e       i_width,
    input  logic                     i_uload,
    output logic [execPkg::XLEN-1:0] o_rdata,
    output logic                     o_done,
    output logic                     o_busy,

    // Bus side
    input  logic [execPkg::XLEN-1:0] i_lsuRdata,
    output logic [execPkg::XLEN-1:0] o_lsuWdata,
    output logic [execPkg::XLEN-1:0] o_lsuAddr,
    output logic                     o_lsuWe,
    output execPkg::memWidth_e       o_lsuHb,
    output logic                     o_lsuReq,
    input  logic                     i_lsuGnt
);

    execPkg::lsuState_e       state;
    logic                     weQ;
    logic [execPkg::XLEN-1:0] addrQ;
    logic [execPkg::XLEN-1:0] wdataQ;
    execPkg::memWidth_e       widthQ;
    logic                     uloadQ;
    logic [execPkg::XLEN-1:0] wdataLanes;
    logic [execPkg::XLEN-1:0] rdShift;
    logic                     capture;

    assign capture = i_start;

    // ------------------------------
    // Handshake FSM
    // ------------------------------
    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            state <= execPkg::IDLE;
            weQ   <= 1'b0;
        end else begin
            case (state)
                execPkg::IDLE: begin
                    if (i_start) begin
                        state <= execPkg::WAIT_GNT;       // Request goes out next cycle
                        weQ   <= i_we;
                    end
                end
                execPkg::WAIT_GNT: begin
                    if (i_lsuGnt) begin
                        state <= execPkg::IDLE;           // Access completes on this edge
                        weQ   <= 1'b0;
                    end
                end
                default: begin
                    state <= execPkg::IDLE;
                end
            endcase
        end
    end

    // Store data is replicated so the addressed lane always carries it
    always_comb begin
        case (i_width)
            execPkg::BYTE: wdataLanes = {4{i_wdata[7:0]}};
            execPkg::HALF: wdataLanes = {2{i_wdata[15:0]}};
            default:       wdataLanes = i_wdata;
        endcase
    end

    always_ff @(posedge i_CLK) begin
        if (capture) begin
            addrQ  <= i_addr;
            wdataQ <= wdataLanes;
            widthQ <= i_width;
            uloadQ <= i_uload;
        end
    end

    assign o_lsuReq   = (state == execPkg::WAIT_GNT);
    assign o_busy     = o_lsuReq;
    assign o_done     = o_lsuReq && i_lsuGnt;      // Pulse on the grant edge
    assign o_lsuAddr  = addrQ;                     // Full byte address goes to the bus
    assign o_lsuWdata = wdataQ;
    assign o_lsuWe    = weQ;
    assign o_lsuHb    = widthQ;

    // ------------------------------
    // Load extraction
    // ------------------------------
    assign rdShift = i_lsuRdata >> {addrQ[1:0], 3'b000}; // Move the addressed lane to bit 0

    always_comb begin
        case (widthQ)
            execPkg::BYTE: begin
                o_rdata = {{(execPkg::XLEN-8){~uloadQ & rdShift[7]}}, rdShift[7:0]};
            end
            execPkg::HALF: begin
                o_rdata = {{(execPkg::XLEN-16){~uloadQ & rdShift[15]}}, rdShift[15:0]};
            end
            default: begin
                o_rdata = i_lsuRdata;
            end
        endcase
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // The bus may take any number of cycles and nothing may move while it waits
    assert property (@(posedge i_CLK) disable iff (i_rst)
        (o_lsuReq && !i_lsuGnt) |=> (o_lsuReq && $stable(o_lsuAddr) && $stable(o_lsuWe)
            && $stable(o_lsuHb) && $stable(o_lsuWdata)));

    // Addresses come from the ALU in the execute stage
    assert property (@(posedge i_CLK) disable iff (i_rst)
        (capture && i_width == execPkg::HALF) |-> !i_addr[0]);
    assert property (@(posedge i_CLK) disable iff (i_rst)
        (capture && i_width == execPkg::WORD) |-> (i_addr[1:0] == 2'b00));

endmodule

/* sim.f */
hdl/execPkg.sv
hdl/alu.sv
hdl/lsu.sv
hdl/execute.sv
tests/execute_tb.sv

/* tests/execute_tb.sv */
`timescale 1ns/1ps

module execute_tb;

    logic                     clk;
    logic                     rst;
    logic                     en;
    logic [31:0]              pc;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [4:0]               rdPtr;
    logic [31:0]              rs1;
    logic [31:0]              rs2;
    logic [31:0]              immVal;
    logic [1:0]               aluCtl;
    logic                     regWe;
    logic                     memWe;
    logic                     memRe;
    logic                     imm;
    logic                     jal;
    logic                     lui;
    logic                     auipc;
    logic [execPkg::XLEN-1:0] rdOut;
    logic [4:0]               rdPtrOut;
    logic                     regWeOut;
    logic                     busy;
    logic [execPkg::XLEN-1:0] lsuRdata;
    logic [execPkg::XLEN-1:0] lsuWdata;
    logic [execPkg::XLEN-1:0] lsuAddr;
    logic                     lsuWe;
    execPkg::memWidth_e       lsuHb;
    logic                     lsuReq;
    logic                     lsuGnt;

    // Test table with one entry per line of the data file
    string       tName[64];
    logic [2:0]  tFunct3[64];
    logic [6:0]  tFunct7[64];
    logic [4:0]  tRd[64];
    int          tCtl[64];
    logic [6:0]  tFlags[64];                      // regWe memWe memRe imm jal lui auipc
    logic [31:0] tPc[64];
    logic [31:0] tRs1[64];
    logic [31:0] tRs2[64];
    logic [31:0] tImm[64];
    int          tDelay[64];
    logic [31:0] tRdata[64];
    logic [31:0] tExpRd[64];
    logic [31:0] tExpAddr[64];
    logic [31:0] tExpWdata[64];
    int          tHb[64];
    int          numTests;
    int          maxDelay;
    bit          loadDone;
    int          testErrors;
    int          passCount;
    int          failCount;
    int          curDelay;
    logic [31:0] curRdata;
    int          reqCycles;

    execute i_execute (
        .i_CLK (clk), .i_rst (rst), .i_en (en), .i_pc (pc), .i_funct3 (funct3),
        .i_funct7 (funct7), .i_rdPtr (rdPtr), .i_rs1 (rs1), .i_rs2 (rs2),
        .i_immVal (immVal), .i_aluOp (aluCtl), .i_regWe (regWe), .i_memWe (memWe),
        .i_memRe (memRe), .i_imm (imm), .i_jal (jal), .i_lui (lui), .i_auipc (auipc),
        .o_rd (rdOut), .o_rdPtr (rdPtrOut), .o_regWe (regWeOut), .o_busy (busy),
        .i_lsuRdata (lsuRdata), .o_lsuWdata (lsuWdata), .o_lsuAddr (lsuAddr),
        .o_lsuWe (lsuWe), .o_lsuHb (lsuHb), .o_lsuReq (lsuReq), .i_lsuGnt (lsuGnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                    // 4 ns period
    end

    // ------------------------------
    // Bus responder
    // ------------------------------
    // Counts cycles in which the request is (or is about to be) up and not yet granted
    always @(posedge clk) begin
        if (rst) begin
            lsuGnt    <= 1'b0;
            reqCycles <= 0;
        end else if ((lsuReq && !lsuGnt) || (en && (memRe || memWe))) begin
            if (reqCycles == curDelay) begin
                lsuGnt    <= 1'b1;
                lsuRdata  <= curRdata;            // Valid only in the grant cycle
                reqCycles <= 0;
            end else begin
                lsuGnt    <= 1'b0;
                lsuRdata  <= 32'h0bad0bad;
                reqCycles <= reqCycles + 1;
            end
        end else begin
            lsuGnt    <= 1'b0;
            lsuRdata  <= 32'h0bad0bad;
            reqCycles <= 0;
        end
    end

    task automatic loadTests();
        int    fd;
        int    got;
        string line;
        numTests = 0;
        maxDelay = 0;
        fd = $fopen("tests/execute_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && numTests < 64) begin
                got = $fgets(line, fd);
                if (got != 0 && line.len() > 1 && line[0] != "#") begin
                    got = $sscanf(line, "%s %h %h %h %d %b %h %h %h %h %d %h %h %h %h %d",
                        tName[numTests], tFunct3[numTests], tFunct7[numTests],
                        tRd[numTests], tCtl[numTests], tFlags[numTests], tPc[numTests],
                        tRs1[numTests], tRs2[numTests], tImm[numTests], tDelay[numTests],
                        tRdata[numTests], tExpRd[numTests], tExpAddr[numTests],
                        tExpWdata[numTests], tHb[numTests]);
                    if (got == 16) begin
                        if (tDelay[numTests] > maxDelay) maxDelay = tDelay[numTests];
                        numTests++;
                    end
                end
            end
            $fclose(fd);
        end
        loadDone = 1'b1;
    endtask

    task automatic compareValue(input string sigName, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, sigName, got, exp);
            testErrors++;
        end
    endtask

    task automatic reportTest(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("PASS %s", name);
        end else begin
            failCount++;
            $display("FAIL %s with %0d errors", name, testErrors);
        end
    endtask

    task automatic driveInstr(input int k);
        en     <= 1'b1;
        pc     <= tPc[k];
        funct3 <= tFunct3[k];
        funct7 <= tFunct7[k];
        rdPtr  <= tRd[k];
        rs1    <= tRs1[k];
        rs2    <= tRs2[k];
        immVal <= tImm[k];
        aluCtl <= 2'(tCtl[k]);
        {regWe, memWe, memRe, imm, jal, lui, auipc} <= tFlags[k];
    endtask

    // Sampled one cycle after the instruction was taken
    task automatic checkAluWriteback(input int k);
        compareValue("o_regWe", regWeOut, tFlags[k][6]);
        if (tFlags[k][6]) begin
            compareValue("o_rd", rdOut, tExpRd[k]);
            compareValue("o_rdPtr", rdPtrOut, tRd[k]);
        end
        compareValue("o_busy", busy, 0);
        compareValue("o_lsuReq", lsuReq, 0);
    endtask

    task automatic runAluTest(input int k);
        @(posedge clk);
        driveInstr(k);
        @(posedge clk);
        en <= 1'b0;
        @(negedge clk);
        checkAluWriteback(k);
        @(negedge clk);
        compareValue("o_regWe", regWeOut, 0);     // Pulse is a single cycle
    endtask

    task automatic runMemTest(input int k);
        int reqCount;
        bit granted;
        reqCount = 0;
        granted  = 1'b0;
        curDelay = tDelay[k];
        curRdata = tRdata[k];
        @(posedge clk);
        driveInstr(k);
        @(posedge clk);
        en <= 1'b0;
        while (!granted) begin
            @(negedge clk);
            compareValue("o_lsuReq", lsuReq, 1);
            compareValue("o_busy", busy, 1);
            compareValue("o_lsuAddr", lsuAddr, tExpAddr[k]);
            compareValue("o_lsuWdata", lsuWdata, tExpWdata[k]);
            compareValue("o_lsuWe", lsuWe, tFlags[k][5]);
            compareValue("o_lsuHb", 32'(lsuHb), tHb[k]);
            reqCount++;
            granted = lsuGnt || !lsuReq || (reqCount > tDelay[k] + 1);
        end
        if (reqCount != tDelay[k] + 1) begin
            $display("Bus request lasted %0d cycles instead of %0d", reqCount, tDelay[k] + 1);
            testErrors++;
        end
        @(negedge clk);
        compareValue("o_lsuReq", lsuReq, 0);
        compareValue("o_busy", busy, 0);
        compareValue("o_regWe", regWeOut, tFlags[k][6] && tFlags[k][4]);
        if (tFlags[k][6] && tFlags[k][4]) begin
            compareValue("o_rd", rdOut, tExpRd[k]);
            compareValue("o_rdPtr", rdPtrOut, tRd[k]);
        end
        @(negedge clk);
        compareValue("o_regWe", regWeOut, 0);
    endtask

    // Every ALU entry of the table issued on consecutive cycles
    task automatic backToBack();
        int idx[$];
        int k;
        for (k = 0; k < numTests; k++) begin
            if (tFlags[k][5:4] == 2'b00) idx.push_back(k);
        end
        testErrors = 0;
        for (k = 0; k <= idx.size(); k++) begin
            @(posedge clk);
            if (k < idx.size()) driveInstr(idx[k]);
            else en <= 1'b0;
            @(negedge clk);
            if (k > 0) checkAluWriteback(idx[k-1]);
        end
        reportTest("back_to_back");
    endtask

    task automatic runAll();
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        testErrors = 0;
        compareValue("o_lsuReq", lsuReq, 0);
        compareValue("o_regWe", regWeOut, 0);
        compareValue("o_busy", busy, 0);
        compareValue("o_rd", rdOut, 0);
        reportTest("reset");
        for (int k = 0; k < numTests; k++) begin
            repeat ($urandom % 4) @(posedge clk);  // Idle gap between instructions
            testErrors = 0;
            if (tFlags[k][5] || tFlags[k][4]) runMemTest(k);
            else runAluTest(k);
            reportTest(tName[k]);
        end
        backToBack();
    endtask

    initial begin
        void'($urandom(76098));
        rst      = 1'b1;
        en       = 1'b0;
        pc       = '0;
        funct3   = '0;
        funct7   = '0;
        rdPtr    = '0;
        rs1      = '0;
        rs2      = '0;
        immVal   = '0;
        aluCtl   = '0;
        {regWe, memWe, memRe, imm, jal, lui, auipc} = '0;
        lsuGnt   = 1'b0;
        lsuRdata = '0;
        curDelay = 0;
        curRdata = '0;
        loadTests();
        if (numTests == 0) begin
            $display("No test could be read from tests/execute_tests.txt");
            $display("sim failed");
            $finish;
        end else begin
            runAll();
            $display("Tests passed: %0d, failed: %0d", passCount, failCount);
            if (failCount == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        wait (loadDone);
        repeat (numTests * (maxDelay + 20)) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not complete",
            numTests * (maxDelay + 20));
        $display("sim failed");
        $finish;
    end

endmodule

/* tests/execute_tests.txt */
# name f3 f7 rd ctl flags(regWe memWe memRe imm jal lui auipc) pc rs1 rs2 imm
# delay rdata expRd expAddr expWdata expHb (hex except ctl, flags, delay and expHb)
add     0 00 01 1 1000000 0    5        7        0        0 0        c        0    0        0
sub     0 20 02 1 1000000 0    5        7        0        0 0        fffffffe 0    0        0
addi_f7 0 20 03 1 1001000 0    100      0        fffffffc 0 0        fc       0    0        0
sll     1 00 04 1 1000000 0    3        24       0        0 0        30       0    0        0
srl     5 00 05 1 1000000 0    80000000 4        0        0 0        8000000  0    0        0
sra     5 20 06 1 1000000 0    80000000 4        0        0 0        f8000000 0    0        0
slt     2 00 07 1 1000000 0    ffffffff 1        0        0 0        1        0    0        0
sltu    3 00 08 1 1000000 0    ffffffff 1        0        0 0        0        0    0        0
xor     4 00 09 1 1000000 0    ff00ff00 f0f0f0f  0        0 0        f00ff00f 0    0        0
or      6 00 0a 1 1000000 0    ff00ff00 f0f0f0f  0        0 0        ff0fff0f 0    0        0
andi    7 00 0b 1 1001000 0    ff00ff00 0        ff0      0 0        f00      0    0        0
lui     0 00 0c 0 1001010 0    12345678 0        abcde000 0 0        abcde000 0    0        0
auipc   0 00 0d 0 1001001 1000 0        0        2000     0 0        3000     0    0        0
jal     0 00 0e 0 1001100 200  0        0        4        0 0        204      0    0        0
nowe    0 00 0f 1 0000000 0    1        2        0        0 0        3        0    0        0
sb      0 00 00 0 0101000 0    1000     123456a5 3        0 0        0        1003 a5a5a5a5 0
sh      1 00 00 0 0101000 0    2000     9999beef 2        1 0        0        2002 beefbeef 1
sw      2 00 00 0 0101000 0    3000     cafef00d 4        5 0        0        3004 cafef00d 2
lb0     0 00 10 0 1011000 0    4000     0        0        0 80f17f82 ffffff82 4000 0        0
lb1     0 00 11 0 1011000 0    4000     0        1        1 80f17f82 7f       4001 0        0
lb2     0 00 12 0 1011000 0    4000     0        2        2 80f17f82 fffffff1 4002 0        0
lb3     0 00 13 0 1011000 0    4000     0        3        3 80f17f82 ffffff80 4003 0        0
lbu2    4 00 14 0 1011000 0    4000     0        2        0 80f17f82 f1       4002 0        0
lbu3    4 00 15 0 1011000 0    4000     0        3        1 80f17f82 80       4003 0        0
lh0     1 00 16 0 1011000 0    4000     0        0        2 80f17f82 7f82     4000 0        1
lh2     1 00 17 0 1011000 0    4000     0        2        5 80f17f82 ffff80f1 4002 0        1
lhu2    5 00 18 0 1011000 0    4000     0        2        0 80f17f82 80f1     4002 0        1
lw      2 00 19 0 1011000 0    4000     0        8        3 80f17f82 80f17f82 4008 0        2
